/* Makefile */
TOP = i2c_master_tb

all: run

build:
	verilator --binary --timing --assert -f verilog.f --top-module $(TOP) -Mdir obj_dir -o sim

run: build
	./obj_dir/sim | tee sim.log
	@if grep -q "Testbench failed" sim.log; then exit 1; fi
	@grep -q "Testbench passed" sim.log

lint:
	verilator --lint-only -Wall --timing -f verilog.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

.PHONY: all build run lint clean

/* logic/i2c_bit_timer.sv */
module i2c_bit_timer (
    input  logic                                clock,
    input  logic                                reset_n,
    input  logic                                enable,
    input  logic [i2c_pkg::DIVIDER_WIDTH-1:0]   divider,
    output logic                                tick
);
    import i2c_pkg::*;

    logic [DIVIDER_WIDTH-1:0] count;
    logic [DIVIDER_WIDTH-1:0] saved_divider;

    // Follows the input while idle, so the value present with start is kept
    always_ff @(posedge clock) begin
        if (!enable) begin
            saved_divider <= divider;
        end
    end

    always_ff @(posedge clock) begin
        if (!reset_n) begin
            count <= '0;
            tick  <= 1'b0;
        end else if (!enable) begin
            count <= '0;          // Fresh quarter for every transfer
            tick  <= 1'b0;
        end else if (count == saved_divider) begin
            count <= '0;
            tick  <= 1'b1;
        end else begin
            count <= count + 1'b1;
            tick  <= 1'b0;
        end
    end

endmodule

/* logic/i2c_byte_engine.sv */
module i2c_byte_engine (
    input  logic                            clock,
    input  logic                            reset_n,
    input  logic                            tick,
    input  logic                            cmd_valid,
    input  i2c_pkg::bus_cmd_t               cmd,
    input  logic                            scl_in,
    input  logic                            sda_in,
    output logic                            scl_oe,
    output logic                            sda_oe,
    output logic                            op_done,
    output logic                            acked,
    output logic [i2c_pkg::BYTE_WIDTH-1:0]  rx_byte
);
    import i2c_pkg::*;

    logic                       active;
    bus_op_t                    op;
    logic [QUARTER_WIDTH-1:0]   quarter;
    logic [BIT_COUNT_WIDTH-1:0] bit_count;
    logic [BYTE_WIDTH-1:0]      shift;
    logic                       is_byte;
    logic                       ack_bit;
    logic                       last_bit;
    logic                       sample;

    assign is_byte  = (op == op_write_byte) || (op == op_read_byte);
    assign ack_bit  = bit_count == BIT_COUNT_WIDTH'(BYTE_WIDTH);
    assign last_bit = !is_byte || ack_bit;
    // SCL high seen in the third quarter
    assign sample   = active && tick && (quarter == QUARTER_WIDTH'(2)) && scl_in;
    assign op_done  = active && tick && (quarter == QUARTER_WIDTH'(QUARTERS_PER_BIT - 1)) && last_bit;
    assign rx_byte  = shift;

    // Shared for both directions, MSB leaves first and bus bits enter at the LSB
    always_ff @(posedge clock) begin
        if (!active && cmd_valid) begin
            op <= cmd.op;
            if (cmd.op == op_write_byte) begin
                shift <= cmd.tx_byte;   // Other operations keep the received byte
            end
        end else if (sample && is_byte && !ack_bit) begin
            shift <= {shift[BYTE_WIDTH-2:0], sda_in};
        end
    end

    always_ff @(posedge clock) begin
        if (!reset_n) begin
            active    <= 1'b0;
            quarter   <= '0;
            bit_count <= '0;
            scl_oe    <= 1'b0;
            sda_oe    <= 1'b0;
            acked     <= 1'b0;
        end else if (!active) begin
            if (cmd_valid) begin
                active    <= 1'b1;
                quarter   <= '0;
                bit_count <= '0;
            end
        end else if (tick) begin
            case (quarter)
                QUARTER_WIDTH'(0): begin
                    // SCL is low here, so SDA may change
                    case (op)
                        op_write_byte: sda_oe <= !ack_bit && !shift[BYTE_WIDTH-1];
                        op_stop:       sda_oe <= 1'b1;
                        default:       sda_oe <= 1'b0; // Release, also NACK on a read
                    endcase
                    quarter <= quarter + 1'b1;
                end
                QUARTER_WIDTH'(1): begin
                    scl_oe  <= 1'b0;
                    quarter <= quarter + 1'b1;
                end
                QUARTER_WIDTH'(2): begin
                    if (scl_in) begin               // Target may still stretch
                        if (op == op_start || op == op_restart) begin
                            sda_oe <= 1'b1;         // START while SCL high
                        end
                        if (is_byte && ack_bit) begin
                            acked <= !sda_in;
                        end
                        quarter <= quarter + 1'b1;
                    end
                end
                default: begin
                    if (op == op_stop) begin
                        sda_oe <= 1'b0;             // STOP, bus released
                    end else begin
                        scl_oe <= 1'b1;
                    end
                    quarter <= '0;
                    if (last_bit) begin
                        active <= 1'b0;
                    end else begin
                        bit_count <= bit_count + 1'b1;
                    end
                end
            endcase
        end
    end

endmodule

/* logic/i2c_master.sv */
module i2c_master (
    input  logic                                clock,
    input  logic                                reset_n,
    input  logic                                start,
    input  i2c_pkg::i2c_request_t               request,
    input  logic [i2c_pkg::DIVIDER_WIDTH-1:0]   divider,
    input  logic                                scl_in,
    input  logic                                sda_in,
    output logic                                busy,
    output logic                                done,
    output logic                                error,
    output logic [i2c_pkg::BYTE_WIDTH-1:0]      read_data,
    output logic                                scl_oe,
    output logic                                sda_oe
);
    import i2c_pkg::*;

    logic                  tick;
    logic                  cmd_valid;
    bus_cmd_t              cmd;
    logic                  op_done;
    logic                  acked;
    logic [BYTE_WIDTH-1:0] rx_byte;

    i2c_bit_timer u_bit_timer (
        .clock   (clock),
        .reset_n (reset_n),
        .enable  (busy),          // Quarter ticks only during a transfer
        .divider (divider),
        .tick    (tick)
    );

    i2c_byte_engine u_byte_engine (
        .clock     (clock),
        .reset_n   (reset_n),
        .tick      (tick),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .scl_in    (scl_in),
        .sda_in    (sda_in),
        .scl_oe    (scl_oe),
        .sda_oe    (sda_oe),
        .op_done   (op_done),
        .acked     (acked),
        .rx_byte   (rx_byte)
    );

    i2c_sequencer u_sequencer (
        .clock     (clock),
        .reset_n   (reset_n),
        .start     (start),
        .request   (request),
        .op_done   (op_done),
        .acked     (acked),
        .rx_byte   (rx_byte),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .busy      (busy),
        .done      (done),
        .error     (error),
        .read_data (read_data)
    );

endmodule

/* logic/i2c_pkg.sv */
package i2c_pkg;

    localparam int DEVICE_ADDRESS_WIDTH = 7;
    localparam int BYTE_WIDTH = 8;
    localparam int DIVIDER_WIDTH = 16;
    localparam int QUARTERS_PER_BIT = 4;
    localparam int QUARTER_WIDTH = $clog2(QUARTERS_PER_BIT);
    localparam int BIT_COUNT_WIDTH = $clog2(BYTE_WIDTH + 1); // Eight data bits plus acknowledge

    typedef struct packed {
        logic                            read_write; // 1 for a register read
        logic [DEVICE_ADDRESS_WIDTH-1:0] device_address;
        logic [BYTE_WIDTH-1:0]           register_address;
        logic [BYTE_WIDTH-1:0]           write_data;
    } i2c_request_t;

    typedef enum logic [2:0] {
        op_start,
        op_restart,
        op_write_byte,
        op_read_byte,
        op_stop
    } bus_op_t;

    typedef struct packed {
        bus_op_t               op;
        logic [BYTE_WIDTH-1:0] tx_byte;
    } bus_cmd_t;

    typedef enum logic [3:0] {
        idle,
        send_start,
        send_device_write,
        send_register,
        send_data,
        send_restart,
        send_device_read,
        receive_data,
        send_stop
    } sequence_state_t;

endpackage

/* logic/i2c_sequencer.sv */
module i2c_sequencer (
    input  logic                            clock,
    input  logic                            reset_n,
    input  logic                            start,
    input  i2c_pkg::i2c_request_t           request,
    input  logic                            op_done,
    input  logic                            acked,
    input  logic [i2c_pkg::BYTE_WIDTH-1:0]  rx_byte,
    output logic                            cmd_valid,
    output i2c_pkg::bus_cmd_t               cmd,
    output logic                            busy,
    output logic                            done,
    output logic                            error,
    output logic [i2c_pkg::BYTE_WIDTH-1:0]  read_data
);
    import i2c_pkg::*;

    sequence_state_t state;
    sequence_state_t next_state;
    i2c_request_t    saved_request;
    logic            nack_seen;
    logic            expects_ack;

    assign expects_ack = state inside {send_device_write, send_register, send_data,
                                       send_device_read};

    // One bus operation per state
    always_comb begin
        cmd.op      = op_stop;
        cmd.tx_byte = '0;
        case (state)
            send_start:   cmd.op = op_start;
            send_restart: cmd.op = op_restart;
            receive_data: cmd.op = op_read_byte;
            send_device_write: begin
                cmd.op      = op_write_byte;
                cmd.tx_byte = {saved_request.device_address, 1'b0};
            end
            send_register: begin
                cmd.op      = op_write_byte;
                cmd.tx_byte = saved_request.register_address;
            end
            send_data: begin
                cmd.op      = op_write_byte;
                cmd.tx_byte = saved_request.write_data;
            end
            send_device_read: begin
                cmd.op      = op_write_byte;
                cmd.tx_byte = {saved_request.device_address, 1'b1};
            end
            default: cmd.op = op_stop;
        endcase
    end

    // Step taken when the current operation completes
    always_comb begin
        case (state)
            send_start:        next_state = send_device_write;
            send_device_write: next_state = acked ? send_register : send_stop;
            send_register: begin
                if (!acked) begin
                    next_state = send_stop;
                end else if (saved_request.read_write) begin
                    next_state = send_restart;
                end else begin
                    next_state = send_data;
                end
            end
            send_data:         next_state = send_stop;
            send_restart:      next_state = send_device_read;
            send_device_read:  next_state = acked ? receive_data : send_stop;
            receive_data:      next_state = send_stop;
            default:           next_state = idle;
        endcase
    end

    always_ff @(posedge clock) begin
        if (start && state == idle && !done) begin
            saved_request <= request;
        end
    end

    always_ff @(posedge clock) begin
        if (!reset_n) begin
            state     <= idle;
            cmd_valid <= 1'b0;
            busy      <= 1'b0;
            done      <= 1'b0;
            error     <= 1'b0;
            nack_seen <= 1'b0;
            read_data <= '0;
        end else begin
            cmd_valid <= 1'b0;
            done      <= 1'b0;
            if (state == idle) begin
                if (done) begin
                    busy <= 1'b0;                   // Busy ends after the done cycle
                end else if (start) begin
                    state     <= send_start;
                    busy      <= 1'b1;
                    cmd_valid <= 1'b1;
                    nack_seen <= 1'b0;
                end
            end else if (op_done) begin
                state <= next_state;
                if (expects_ack && !acked) begin
                    nack_seen <= 1'b1;
                end
                if (state == send_stop) begin
                    done  <= 1'b1;
                    error <= nack_seen;
                    // Engine still holds the received byte through the stop
                    if (saved_request.read_write && !nack_seen) begin
                        read_data <= rx_byte;
                    end
                end else begin
                    cmd_valid <= 1'b1;
                end
            end
        end
    end

endmodule

/* verif/i2c_master_checker.sv */
module i2c_master_checker (
    input logic clock,
    input logic reset_n,
    input logic busy,
    input logic done,
    input logic error,
    input logic scl_oe,
    input logic sda_oe
);

    done_single_cycle: assert property (@(posedge clock) disable iff (!reset_n)
        done |=> !done)
        else $error("done held for more than one cycle");

    busy_ends_after_done: assert property (@(posedge clock) disable iff (!reset_n)
        done |=> !busy)
        else $error("busy still high after done");

    bus_released_when_idle: assert property (@(posedge clock) disable iff (!reset_n)
        !busy |-> (!scl_oe && !sda_oe))
        else $error("bus driven while not busy");

    error_moves_with_done: assert property (@(posedge clock) disable iff (!reset_n)
        (error != $past(error)) |-> done)
        else $error("error changed outside a done cycle");

endmodule

bind i2c_master i2c_master_checker u_checker (.*);

/* verif/i2c_master_tb.sv */
module i2c_master_tb;
    import i2c_pkg::*;

    localparam logic [6:0] TARGET_ADDRESS = 7'h50;
    localparam int         TIMEOUT_CYCLES = 200000;
    localparam logic [31:0] SEED          = 32'hdc1d_12e6;

    logic                     clock;
    logic                     reset_n;
    logic                     start;
    i2c_request_t             request;
    logic [DIVIDER_WIDTH-1:0] divider;
    logic                     busy;
    logic                     done;
    logic                     error;
    logic [BYTE_WIDTH-1:0]    read_data;
    logic                     master_scl_oe;
    logic                     master_sda_oe;
    logic                     target_scl_oe;
    logic                     target_sda_oe;
    logic                     scl;
    logic                     sda;
    logic [7:0]               stretch_cycles;
    logic [7:0]               shadow [256];
    logic                     expect_error;
    logic                     expect_data_valid;
    logic [7:0]               expect_data;
    logic [7:0]               used_registers [8];
    int                       done_count;
    int                       check_count;
    int                       error_count;
    bit                       aborted;

    // Open-drain lines, low when anyone pulls
    assign scl = !(master_scl_oe || target_scl_oe);
    assign sda = !(master_sda_oe || target_sda_oe);

    i2c_master DUT (
        .clock     (clock),
        .reset_n   (reset_n),
        .start     (start),
        .request   (request),
        .divider   (divider),
        .scl_in    (scl),
        .sda_in    (sda),
        .busy      (busy),
        .done      (done),
        .error     (error),
        .read_data (read_data),
        .scl_oe    (master_scl_oe),
        .sda_oe    (master_sda_oe)
    );

    i2c_target_model #(.ADDRESS(TARGET_ADDRESS)) u_target (
        .clock          (clock),
        .reset_n        (reset_n),
        .scl            (scl),
        .sda            (sda),
        .stretch_cycles (stretch_cycles),
        .scl_oe         (target_scl_oe),
        .sda_oe         (target_sda_oe)
    );

    initial begin
        clock = 1'b0;
        forever #5 clock = !clock;
    end

    function automatic logic [7:0] expected_read(input logic [7:0] register_address);
        return shadow[register_address];   // Zero until written
    endfunction

    function automatic logic expected_error(input logic [6:0] device_address);
        return device_address != TARGET_ADDRESS;
    endfunction

    always @(posedge clock) begin
        if (reset_n && done) begin
            done_count++;
            check_count++;
            if (error !== expect_error) begin
                $display("FAIL error: expected %h, got %h", expect_error, error);
                error_count++;
            end
            if (expect_data_valid && read_data !== expect_data) begin
                $display("FAIL read_data: expected %h, got %h", expect_data, read_data);
                error_count++;
            end
        end
    end

    task automatic wait_for_done(input int target_count);
        int cycles;
        cycles = 0;
        while (done_count < target_count && cycles < TIMEOUT_CYCLES) begin
            @(negedge clock);
            cycles++;
        end
        if (done_count < target_count) begin
            $display("Timeout: no done pulse within %0d cycles", TIMEOUT_CYCLES);
            error_count++;
            aborted = 1'b1;
        end
    endtask

    task automatic launch_request(input logic rw, input logic [6:0] device,
                                  input logic [7:0] register, input logic [7:0] data);
        @(negedge clock);
        request.read_write       = rw;
        request.device_address   = device;
        request.register_address = register;
        request.write_data       = data;
        expect_error      = expected_error(device);
        expect_data_valid = rw && !expected_error(device);
        expect_data       = expected_read(register);
        start = 1'b1;
        @(negedge clock);
        start = 1'b0;
    endtask

    task automatic run_request(input logic rw, input logic [6:0] device,
                               input logic [7:0] register, input logic [7:0] data);
        int target_count;
        if (!aborted) begin
            target_count = done_count + 1;
            launch_request(rw, device, register, data);
            wait_for_done(target_count);
            if (!aborted && !rw && !expected_error(device)) begin
                shadow[register] = data;
            end
        end
    endtask

    task automatic check_bus_released();
        @(negedge clock);
        check_count++;
        if (master_scl_oe !== 1'b0 || master_sda_oe !== 1'b0) begin
            $display("FAIL scl_oe/sda_oe: expected 0/0, got %h/%h",
                     master_scl_oe, master_sda_oe);
            error_count++;
        end
        if (scl !== 1'b1 || sda !== 1'b1) begin
            $display("FAIL scl/sda: expected 1/1, got %h/%h", scl, sda);
            error_count++;
        end
    endtask

    task automatic write_then_read(input int count);
        for (int i = 0; i < count; i++) begin
            used_registers[i] = 8'($urandom);
            run_request(1'b0, TARGET_ADDRESS, used_registers[i], 8'($urandom));
        end
        for (int i = 0; i < count; i++) begin
            run_request(1'b1, TARGET_ADDRESS, used_registers[i], 8'h00);
        end
    endtask

    task automatic ignore_start_while_busy();
        int target_count;
        int cycles;
        logic [7:0] register;
        if (!aborted) begin
            register = 8'($urandom);
            target_count = done_count + 1;
            launch_request(1'b0, TARGET_ADDRESS, register, 8'h5a);
            repeat (3) @(negedge clock);
            if (!busy) begin
                $display("busy was low during an active transfer");
                error_count++;
            end
            request.write_data = 8'ha5;          // Second request must be dropped
            start = 1'b1;
            @(negedge clock);
            start = 1'b0;
            wait_for_done(target_count);
            if (!aborted) begin
                shadow[register] = 8'h5a;
                cycles = 0;
                while (cycles < 2000) begin
                    @(negedge clock);
                    cycles++;
                end
                if (done_count != target_count) begin
                    $display("A start strobe while busy produced an extra done");
                    error_count++;
                end
                run_request(1'b1, TARGET_ADDRESS, register, 8'h00);
            end
        end
    endtask

    task automatic report();
        $display("Done pulses: %0d, checks: %0d, errors: %0d",
                 done_count, check_count, error_count);
        if (error_count == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    endtask

    initial begin
        logic [6:0] other_address;
        void'($urandom(SEED));
        reset_n           = 1'b0;
        start             = 1'b0;
        request           = '0;
        divider           = 16'd3;
        stretch_cycles    = '0;
        expect_error      = 1'b0;
        expect_data_valid = 1'b0;
        expect_data       = '0;
        done_count        = 0;
        check_count       = 0;
        error_count       = 0;
        aborted           = 1'b0;
        for (int i = 0; i < 256; i++) begin
            shadow[i] = '0;
        end
        repeat (3) @(posedge clock);
        @(negedge clock);
        reset_n = 1'b1;

        write_then_read(8);

        // Wrong device address
        do begin
            other_address = 7'($urandom);
        end while (other_address == TARGET_ADDRESS);
        run_request(1'b0, other_address, 8'($urandom), 8'($urandom));
        if (!aborted) check_bus_released();
        run_request(1'b1, other_address, 8'($urandom), 8'h00);
        if (!aborted) check_bus_released();

        ignore_start_while_busy();

        for (int i = 0; i < 6; i++) begin
            divider = (i == 0) ? 16'd0 : (i == 1) ? 16'd1 : 16'(2 + $urandom % 20);
            write_then_read(2);
        end

        divider = 16'd2;
        stretch_cycles = 8'(5 + $urandom % 10);
        write_then_read(4);
        stretch_cycles = '0;

        report();
    end

endmodule

/* verif/i2c_target_model.sv */
module i2c_target_model #(
    parameter logic [6:0] ADDRESS = 7'h50
) (
    input  logic       clock,
    input  logic       reset_n,
    input  logic       scl,
    input  logic       sda,
    input  logic [7:0] stretch_cycles,
    output logic       scl_oe,
    output logic       sda_oe
);
    localparam logic [2:0] MODE_IDLE     = 3'd0;
    localparam logic [2:0] MODE_ADDRESS  = 3'd1;
    localparam logic [2:0] MODE_REGISTER = 3'd2;
    localparam logic [2:0] MODE_WRITE    = 3'd3;
    localparam logic [2:0] MODE_READ     = 3'd4;

    logic [7:0] memory [256];
    logic [2:0] mode;
    logic [7:0] shift;
    logic [7:0] pointer;
    logic [7:0] stretch_count;
    logic [3:0] bit_index;
    logic       prev_scl;
    logic       prev_sda;
    logic       master_acked;
    logic       scl_rise;
    logic       scl_fall;
    logic       start_seen;
    logic       stop_seen;

    assign scl_rise   = !prev_scl && scl;
    assign scl_fall   = prev_scl && !scl;
    assign start_seen = prev_scl && scl && prev_sda && !sda;
    assign stop_seen  = prev_scl && scl && !prev_sda && sda;

    always_ff @(posedge clock) begin
        if (!reset_n) begin
            for (int i = 0; i < 256; i++) begin
                memory[i] <= '0;
            end
            mode          <= MODE_IDLE;
            shift         <= '0;
            pointer       <= '0;
            stretch_count <= '0;
            bit_index     <= '0;
            prev_scl      <= 1'b1;
            prev_sda      <= 1'b1;
            master_acked  <= 1'b0;
            scl_oe        <= 1'b0;
            sda_oe        <= 1'b0;
        end else begin
            prev_scl <= scl;
            prev_sda <= sda;
            if (stretch_count != 0) begin
                stretch_count <= stretch_count - 1'b1;
                if (stretch_count == 8'd1) begin
                    scl_oe <= 1'b0;
                end
            end
            if (start_seen) begin
                mode      <= MODE_ADDRESS;
                bit_index <= '0;
                sda_oe    <= 1'b0;
            end else if (stop_seen) begin
                mode   <= MODE_IDLE;
                sda_oe <= 1'b0;
            end else if (mode != MODE_IDLE && scl_rise) begin
                if (bit_index < 4'd8) begin
                    shift     <= {shift[6:0], sda};   // Also moves the next read bit up
                    bit_index <= bit_index + 1'b1;
                end else if (bit_index == 4'd8) begin
                    master_acked <= !sda;              // Our own ack on address bytes
                    bit_index    <= 4'd9;
                end
            end else if (mode != MODE_IDLE && scl_fall) begin
                if (stretch_cycles != 0) begin
                    scl_oe        <= 1'b1;
                    stretch_count <= stretch_cycles;
                end
                if (bit_index == 4'd8) begin
                    case (mode)
                        MODE_ADDRESS: begin
                            if (shift[7:1] == ADDRESS) begin
                                sda_oe <= 1'b1;
                                mode   <= shift[0] ? MODE_READ : MODE_REGISTER;
                            end else begin
                                mode <= MODE_IDLE;
                            end
                        end
                        MODE_REGISTER: begin
                            pointer <= shift;
                            sda_oe  <= 1'b1;
                            mode    <= MODE_WRITE;
                        end
                        MODE_WRITE: begin
                            memory[pointer] <= shift;
                            sda_oe          <= 1'b1;
                        end
                        default: sda_oe <= 1'b0;       // Master answers a read byte
                    endcase
                end else if (bit_index == 4'd9) begin
                    bit_index <= '0;
                    sda_oe    <= 1'b0;
                    if (mode == MODE_READ) begin
                        if (master_acked) begin
                            shift  <= memory[pointer];
                            sda_oe <= !memory[pointer][7];
                        end else begin
                            mode <= MODE_IDLE;
                        end
                    end
                end else if (mode == MODE_READ && bit_index != 0) begin
                    sda_oe <= !shift[7];
                end
            end
        end
    end

endmodule

/* verilog.f */
logic/i2c_pkg.sv
logic/i2c_bit_timer.sv
logic/i2c_byte_engine.sv
logic/i2c_sequencer.sv
logic/i2c_master.sv
verif/i2c_target_model.sv
verif/i2c_master_checker.sv
verif/i2c_master_tb.sv
